// ==== design/snac_consts.svh ====
// Polling rates, bit counts, widths and SNES swap positions
`ifndef SNAC_CONSTS_SVH
`define SNAC_CONSTS_SVH

// Pad polling rates in Hz
// The strobe runs at twice these rates
`define SNAC_SERLATCH_NORMAL_HZ 200000
`define SNAC_SERLATCH_FAST_HZ   400000
`define SNAC_SNES_COMPAT_HZ     50000

// Clocked bits per poll
`define SNAC_NES_BITS  8
// SNES and DB15 pads
`define SNAC_LONG_BITS 16

// Published button word width
`define SNAC_BTN_W 16

// Width of the bit counter, holds SNAC_LONG_BITS
`define SNAC_CNT_W 5

// Raw bit pairs exchanged for SNES_SWAP
// Bits LO, LO+1 trade places with HI, HI+1
`define SNAC_SWAP_LO 0
`define SNAC_SWAP_HI 8

// Phase accumulator width
`define SNAC_PHASE_W 32

`endif

// ==== design/snac_ctrl_pkg.sv ====
// Controller type and poller state enums
`default_nettype none

package snac_ctrl_pkg;

    // Controller types on the cart port
    // Codes not listed here are treated as DISABLED
    typedef enum logic [4:0] {
        DISABLED  = 5'd0,
        DB15      = 5'd1,
        NES       = 5'd2,
        SNES      = 5'd3,
        DB15_FAST = 5'd9,
        SNES_SWAP = 5'd11
    } gc_type_e;

    // Serial latch poller phases
    typedef enum logic [2:0] {
        IDLE,
        LATCH,
        CLK_LOW,
        CLK_HIGH,
        DONE
    } poll_state_e;

endpackage

`default_nettype wire

// ==== design/snac_port_pkg.sv ====
// Button word and divider step types
`default_nettype none

`include "snac_consts.svh"

package snac_port_pkg;

    // One player's buttons, active high, bit i is the i-th bit shifted in
    typedef logic [`SNAC_BTN_W-1:0] btn_state_t;

    // Phase increment of the strobe divider
    typedef logic [`SNAC_PHASE_W-1:0] step_t;

endpackage

`default_nettype wire

// ==== design/fract_strobe_gen.sv ====
// Phase accumulator divider with single-cycle strobe output
`default_nettype none
`timescale 1ns/100ps

`include "snac_consts.svh"

module fract_strobe_gen (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_restart,
    input  wire snac_port_pkg::step_t  i_step,
    output logic                       o_stb
);

    logic [`SNAC_PHASE_W-1:0] acc_r;
    logic [`SNAC_PHASE_W:0]   sum;

    // Extra top bit holds the carry out
    assign sum = {1'b0, acc_r} + {1'b0, i_step};

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_restart) begin
            acc_r <= '0;
            o_stb <= 1'b0;
        end else begin
            acc_r <= sum[`SNAC_PHASE_W-1:0];
            // Carry is the strobe
            // Steps below half range never carry twice in a row
            o_stb <= sum[`SNAC_PHASE_W];
        end
    end

endmodule

`default_nettype wire

// ==== design/snac_mode_ctrl.sv ====
// Controller type register, change detect and strobe step select
`default_nettype none
`timescale 1ns/100ps

`include "snac_consts.svh"

module snac_mode_ctrl #(
    parameter int unsigned MASTER_CLK_FREQ = 50_000_000
) (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic [4:0]            i_game_cont_type,
    output snac_ctrl_pkg::gc_type_e    o_type,
    output snac_port_pkg::step_t       o_step,
    output logic                       o_restart
);

    // Rounded 2^32 * 2 * rate / clk, strobe at twice the poll rate
    function automatic snac_port_pkg::step_t calc_step(input longint unsigned rate_hz);
        longint unsigned num;
        num = (64'd1 << (`SNAC_PHASE_W + 1)) * rate_hz + MASTER_CLK_FREQ / 2;
        return snac_port_pkg::step_t'(num / MASTER_CLK_FREQ);
    endfunction

    // Map raw code to a known type
    function automatic snac_ctrl_pkg::gc_type_e to_type(input logic [4:0] code);
        snac_ctrl_pkg::gc_type_e t;
        case (code)
            5'd1:    t = snac_ctrl_pkg::DB15;
            5'd2:    t = snac_ctrl_pkg::NES;
            5'd3:    t = snac_ctrl_pkg::SNES;
            5'd9:    t = snac_ctrl_pkg::DB15_FAST;
            5'd11:   t = snac_ctrl_pkg::SNES_SWAP;
            default: t = snac_ctrl_pkg::DISABLED;
        endcase
        return t;
    endfunction

    localparam snac_port_pkg::step_t STEP_NORMAL = calc_step(`SNAC_SERLATCH_NORMAL_HZ);
    localparam snac_port_pkg::step_t STEP_FAST   = calc_step(`SNAC_SERLATCH_FAST_HZ);
    localparam snac_port_pkg::step_t STEP_COMPAT = calc_step(`SNAC_SNES_COMPAT_HZ);

    logic [4:0]           type_raw_r;
    logic [4:0]           type_prev_r;
    snac_port_pkg::step_t step_sel;

    // Step per registered type
    always_comb begin
        case (o_type)
            snac_ctrl_pkg::DB15:      step_sel = STEP_NORMAL;
            snac_ctrl_pkg::DB15_FAST: step_sel = STEP_FAST;
            snac_ctrl_pkg::NES,
            snac_ctrl_pkg::SNES,
            snac_ctrl_pkg::SNES_SWAP: step_sel = STEP_COMPAT;
            // Disabled stops the divider
            default:                  step_sel = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            type_raw_r  <= '0;
            type_prev_r <= '0;
            o_type      <= snac_ctrl_pkg::DISABLED;
            o_step      <= '0;
            // Reset itself counts as a restart
            o_restart   <= 1'b1;
        end else begin
            type_raw_r  <= i_game_cont_type;
            type_prev_r <= type_raw_r;
            o_type      <= to_type(i_game_cont_type);
            // Raw code compare, so a switch between two unknown codes restarts too
            o_restart   <= (type_raw_r != type_prev_r);
            // Step follows o_type, lands together with the restart pulse
            o_step      <= step_sel;
        end
    end

endmodule

`default_nettype wire

// ==== design/serlatch_poller.sv ====
// Serial latch poller driving latch and clock, shifting in two pads
`default_nettype none
`timescale 1ns/100ps

`include "snac_consts.svh"

module serlatch_poller (
    input  wire logic                     i_clk,
    input  wire logic                     i_rst_n,
    input  wire logic                     i_restart,
    input  wire logic                     i_stb,
    input  wire snac_ctrl_pkg::gc_type_e  i_type,
    input  wire logic                     i_dat1,
    input  wire logic                     i_dat2,
    output logic                          o_lat,
    output logic                          o_clk,
    output logic                          o_busy,
    output snac_port_pkg::btn_state_t     o_raw1,
    output snac_port_pkg::btn_state_t     o_raw2,
    output logic                          o_raw_vld
);

    snac_ctrl_pkg::poll_state_e state_r;

    logic [`SNAC_CNT_W-1:0] bit_cnt_r;
    logic [`SNAC_CNT_W-1:0] bit_last;
    logic                   dat1_m_r;
    logic                   dat1_s_r;
    logic                   dat2_m_r;
    logic                   dat2_s_r;

    // NES pads give 8 bits, the rest 16
    assign bit_last = (i_type == snac_ctrl_pkg::NES) ?
                      `SNAC_CNT_W'(`SNAC_NES_BITS - 1) :
                      `SNAC_CNT_W'(`SNAC_LONG_BITS - 1);

    // Two-flop synchronizers on the pad data lines
    always_ff @(posedge i_clk) begin
        dat1_m_r <= i_dat1;
        dat1_s_r <= dat1_m_r;
        dat2_m_r <= i_dat2;
        dat2_s_r <= dat2_m_r;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_restart) begin
            state_r   <= snac_ctrl_pkg::IDLE;
            bit_cnt_r <= '0;
            o_lat     <= 1'b0;
            // Pad clock idles high
            o_clk     <= 1'b1;
            o_busy    <= 1'b0;
            o_raw_vld <= 1'b0;
        end else begin
            o_raw_vld <= 1'b0;
            if (i_stb) begin
                case (state_r)
                    snac_ctrl_pkg::IDLE: begin
                        // Nothing is polled while disabled
                        if (i_type != snac_ctrl_pkg::DISABLED) begin
                            o_busy    <= 1'b1;
                            o_lat     <= 1'b1;
                            bit_cnt_r <= '0;
                            state_r   <= snac_ctrl_pkg::LATCH;
                        end
                    end
                    snac_ctrl_pkg::LATCH: begin
                        // Pads now hold bit 0 on the data line
                        o_lat   <= 1'b0;
                        state_r <= snac_ctrl_pkg::CLK_HIGH;
                    end
                    snac_ctrl_pkg::CLK_HIGH: begin
                        o_clk   <= 1'b0;
                        state_r <= snac_ctrl_pkg::CLK_LOW;
                    end
                    snac_ctrl_pkg::CLK_LOW: begin
                        // Sample on the rising edge, pads then move to the next bit
                        o_clk     <= 1'b1;
                        bit_cnt_r <= bit_cnt_r + 1'b1;
                        if (bit_cnt_r == bit_last) begin
                            state_r <= snac_ctrl_pkg::DONE;
                        end else begin
                            state_r <= snac_ctrl_pkg::CLK_HIGH;
                        end
                    end
                    snac_ctrl_pkg::DONE: begin
                        o_raw_vld <= 1'b1;
                        o_busy    <= 1'b0;
                        state_r   <= snac_ctrl_pkg::IDLE;
                    end
                    default: begin
                        state_r <= snac_ctrl_pkg::IDLE;
                    end
                endcase
            end
        end
    end

    // Shift words, cleared at the poll start so unclocked bits read 0
    always_ff @(posedge i_clk) begin
        if (i_stb && state_r == snac_ctrl_pkg::IDLE) begin
            o_raw1 <= '0;
            o_raw2 <= '0;
        end else if (i_stb && state_r == snac_ctrl_pkg::CLK_LOW) begin
            // Pad lines are active low
            o_raw1[bit_cnt_r[3:0]] <= ~dat1_s_r;
            o_raw2[bit_cnt_r[3:0]] <= ~dat2_s_r;
        end
    end

endmodule

`default_nettype wire

// ==== design/button_mapper.sv ====
// Raw word capture and per-type button mapping for both players
`default_nettype none
`timescale 1ns/100ps

`include "snac_consts.svh"

module button_mapper (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst_n,
    input  wire logic                       i_restart,
    input  wire snac_ctrl_pkg::gc_type_e    i_type,
    input  wire snac_port_pkg::btn_state_t  i_raw1,
    input  wire snac_port_pkg::btn_state_t  i_raw2,
    input  wire logic                       i_raw_vld,
    output snac_port_pkg::btn_state_t       o_p1_btn,
    output snac_port_pkg::btn_state_t       o_p2_btn
);

    // SNES_SWAP trades the two low bits with bits 8,9
    // Other types pass the raw word through
    function automatic snac_port_pkg::btn_state_t map_word(
        input snac_port_pkg::btn_state_t raw,
        input snac_ctrl_pkg::gc_type_e   gc_type
    );
        snac_port_pkg::btn_state_t w;
        w = raw;
        if (gc_type == snac_ctrl_pkg::SNES_SWAP) begin
            w[`SNAC_SWAP_LO +: 2] = raw[`SNAC_SWAP_HI +: 2];
            w[`SNAC_SWAP_HI +: 2] = raw[`SNAC_SWAP_LO +: 2];
        end
        return w;
    endfunction

    logic type_off;

    assign type_off = (i_type == snac_ctrl_pkg::DISABLED);

    always_ff @(posedge i_clk) begin
        // Restart or disabled type forces both players to no buttons
        if (!i_rst_n || i_restart || type_off) begin
            o_p1_btn <= '0;
            o_p2_btn <= '0;
        end else if (i_raw_vld) begin
            // Update lands one cycle after the poll completes
            o_p1_btn <= map_word(i_raw1, i_type);
            o_p2_btn <= map_word(i_raw2, i_type);
        end
    end

endmodule

`default_nettype wire

// ==== design/snac_adapter_top.sv ====
// Top level for the SNAC serial latch adapter with cart pin mapping
`default_nettype none
`timescale 1ns/100ps

module snac_adapter_top #(
    parameter int unsigned MASTER_CLK_FREQ = 50_000_000
) (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic [4:0]            i_game_cont_type,
    input  wire logic [7:4]            i_cart_bk0_in,
    // Pin 30 drives the second pad clock here, its input side is not read
    input  wire logic                  i_cart_pin30_in,
    input  wire logic                  i_cart_pin31_in,
    output snac_port_pkg::btn_state_t  o_p1_btn,
    output snac_port_pkg::btn_state_t  o_p2_btn,
    output logic                       o_busy,
    output logic [7:4]                 o_cart_bk0_out,
    output logic                       o_cart_bk0_dir,
    output logic [7:6]                 o_cart_bk1_out,
    output logic                       o_cart_pin30_out,
    output logic                       o_cart_pin30_dir,
    output logic                       o_cart_pin31_out,
    output logic                       o_cart_pin31_dir
);

    snac_ctrl_pkg::gc_type_e   type_w;
    snac_port_pkg::step_t      step_w;
    snac_port_pkg::btn_state_t raw1_w;
    snac_port_pkg::btn_state_t raw2_w;
    logic                      restart_w;
    logic                      stb_w;
    logic                      lat_w;
    logic                      pad_clk_w;
    logic                      raw_vld_w;
    logic                      is_db15;
    logic                      dat1_w;

    // Fixed pin directions, bank 0 and pin 31 in, pin 30 out
    assign o_cart_bk0_dir   = 1'b0;
    assign o_cart_pin30_dir = 1'b1;
    assign o_cart_pin31_dir = 1'b0;
    assign o_cart_bk0_out   = '0;
    assign o_cart_pin31_out = 1'b0;

    // Shared clock and latch, pin 30 copies the clock for pad 2
    assign o_cart_bk1_out   = {lat_w, pad_clk_w};
    assign o_cart_pin30_out = pad_clk_w;

    // DB15 player 1 data may arrive on either line (crossed cables)
    assign is_db15 = (type_w == snac_ctrl_pkg::DB15) || (type_w == snac_ctrl_pkg::DB15_FAST);
    assign dat1_w  = is_db15 ? (i_cart_bk0_in[4] & i_cart_pin31_in) : i_cart_bk0_in[4];

    snac_mode_ctrl #(
        .MASTER_CLK_FREQ (MASTER_CLK_FREQ)
    ) u_mode_ctrl (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_game_cont_type (i_game_cont_type),
        .o_type           (type_w),
        .o_step           (step_w),
        .o_restart        (restart_w)
    );

    fract_strobe_gen u_strobe_gen (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_restart (restart_w),
        .i_step    (step_w),
        .o_stb     (stb_w)
    );

    serlatch_poller u_poller (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_restart (restart_w),
        .i_stb     (stb_w),
        .i_type    (type_w),
        .i_dat1    (dat1_w),
        .i_dat2    (i_cart_bk0_in[5]),
        .o_lat     (lat_w),
        .o_clk     (pad_clk_w),
        .o_busy    (o_busy),
        .o_raw1    (raw1_w),
        .o_raw2    (raw2_w),
        .o_raw_vld (raw_vld_w)
    );

    button_mapper u_mapper (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_restart (restart_w),
        .i_type    (type_w),
        .i_raw1    (raw1_w),
        .i_raw2    (raw2_w),
        .i_raw_vld (raw_vld_w),
        .o_p1_btn  (o_p1_btn),
        .o_p2_btn  (o_p2_btn)
    );

endmodule

`default_nettype wire

// ==== sim/snac_adapter_assert.sv ====
// Bound protocol assertions on the strobe, pad latch and pad clock
`default_nettype none
`timescale 1ns/100ps

module snac_adapter_assert (
    input wire logic                    i_clk,
    input wire logic                    i_rst_n,
    input wire logic                    i_stb,
    input wire logic                    i_lat,
    input wire logic                    i_pad_clk,
    input wire snac_ctrl_pkg::gc_type_e i_type
);

    // Divider carry is a single-cycle pulse
    stb_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_stb |=> !i_stb)
        else $error("strobe high on two consecutive cycles");

    // Latch only rises while the pad clock idles high
    lat_clk_order: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_lat |-> i_pad_clk)
        else $error("latch high while pad clock is low");

    // Three cycles of DISABLED cover the type register and the restart pulse
    lat_off: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_type == snac_ctrl_pkg::DISABLED &&
         $past(i_type) == snac_ctrl_pkg::DISABLED &&
         $past(i_type, 2) == snac_ctrl_pkg::DISABLED) |-> !i_lat)
        else $error("latch high while the controller type is disabled");

endmodule

bind snac_adapter_top snac_adapter_assert u_snac_assert (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_stb     (stb_w),
    .i_lat     (lat_w),
    .i_pad_clk (pad_clk_w),
    .i_type    (type_w)
);

`default_nettype wire

// ==== sim/tb_snac_adapter.sv ====
// SNAC adapter testbench with pad emulation, reference model, compare tasks and tests
`default_nettype none
`timescale 1ns/100ps

`include "snac_consts.svh"

module tb_snac_adapter;

    localparam int unsigned CLK_HZ = 10_000_000;
    localparam int RESET_CYC = 16;
    // Cycles between strobes, strobe at twice the poll rate
    localparam int STB_COMPAT = CLK_HZ / (2 * `SNAC_SNES_COMPAT_HZ);
    localparam int STB_NORMAL = CLK_HZ / (2 * `SNAC_SERLATCH_NORMAL_HZ);
    localparam int STB_FAST = (CLK_HZ + 2 * `SNAC_SERLATCH_FAST_HZ - 1) / (2 * `SNAC_SERLATCH_FAST_HZ);
    // Start wait, latch, two strobes per bit, done, one spare
    localparam int POLL_STB = 2 * `SNAC_LONG_BITS + 4;
    localparam int N_NES = 20;
    localparam int N_LONG = 10;
    localparam int N_CHANGE = 5;
    localparam int N_OFF = 2;
    // Mid-poll waits before each type switch
    localparam int N_EXTRA = 3;
    localparam int COMPAT_POLLS = N_NES + 2 * N_LONG + N_CHANGE + N_OFF + N_EXTRA;
    localparam int OFF_CYC = N_OFF * POLL_STB * STB_COMPAT;
    localparam int LIMIT = 3 * (RESET_CYC + POLL_STB * (COMPAT_POLLS * STB_COMPAT +
                           N_LONG * STB_NORMAL + N_LONG * STB_FAST)) / 2;

    logic                      clk;
    logic                      rst_n = 1'b0;
    logic [4:0]                game_cont_type = 5'd0;
    logic [7:4]                cart_bk0_in = 4'hF;
    logic                      cart_pin30_in = 1'b0;
    logic                      cart_pin31_in = 1'b1;
    snac_port_pkg::btn_state_t p1_btn;
    snac_port_pkg::btn_state_t p2_btn;
    logic                      busy;
    logic [7:4]                cart_bk0_out;
    logic                      cart_bk0_dir;
    logic [7:6]                cart_bk1_out;
    logic                      cart_pin30_out;
    logic                      cart_pin30_dir;
    logic                      cart_pin31_out;
    logic                      cart_pin31_dir;

    integer                    seed = 80;
    int                        cycle_cnt = 0;

    // Line patterns of the poll in flight, active low as on the pins
    logic [15:0]               line1_r = 16'hFFFF;
    logic [15:0]               line2_r = 16'hFFFF;
    logic [15:0]               line31_r = 16'hFFFF;
    logic [4:0]                pad_idx = 5'd0;
    logic                      lat_q = 1'b0;
    logic                      pclk_q = 1'b1;

    snac_adapter_top #(
        .MASTER_CLK_FREQ (CLK_HZ)
    ) i_snac_adapter_top (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_game_cont_type (game_cont_type),
        .i_cart_bk0_in    (cart_bk0_in),
        .i_cart_pin30_in  (cart_pin30_in),
        .i_cart_pin31_in  (cart_pin31_in),
        .o_p1_btn         (p1_btn),
        .o_p2_btn         (p2_btn),
        .o_busy           (busy),
        .o_cart_bk0_out   (cart_bk0_out),
        .o_cart_bk0_dir   (cart_bk0_dir),
        .o_cart_bk1_out   (cart_bk1_out),
        .o_cart_pin30_out (cart_pin30_out),
        .o_cart_pin30_dir (cart_pin30_dir),
        .o_cart_pin31_out (cart_pin31_out),
        .o_cart_pin31_dir (cart_pin31_dir)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT) begin
            report_failure($sformatf("timeout: no result after %0d cycles", cycle_cnt));
        end
    end

    // Pad 2 is clocked from pin 30, which must follow the shared pad clock
    always @(negedge clk) begin
        if (rst_n) begin
            check_pin(cart_pin30_out, cart_bk1_out[6], "second pad clock");
        end
    end

    // Two pads plus the pin 31 stream, new patterns on each latch rise
    always @(posedge clk) begin : pad_emu
        logic [31:0] rnd1;
        logic [31:0] rnd2;
        logic [31:0] rnd31;
        logic [4:0]  nxt;
        lat_q  <= cart_bk1_out[7];
        pclk_q <= cart_bk1_out[6];
        if (cart_bk1_out[7] && !lat_q) begin
            rnd1  = $random(seed);
            rnd2  = $random(seed);
            rnd31 = $random(seed);
            line1_r  <= rnd1[15:0];
            line2_r  <= rnd2[15:0];
            line31_r <= rnd31[15:0];
            pad_idx  <= 5'd0;
            // Bit 0 goes out while the latch is high
            cart_bk0_in   <= {2'b11, rnd2[0], rnd1[0]};
            cart_pin31_in <= rnd31[0];
        end else if (cart_bk1_out[6] && !pclk_q) begin
            nxt = (pad_idx == 5'd16) ? pad_idx : pad_idx + 5'd1;
            pad_idx <= nxt;
            if (nxt < 5'd16) begin
                cart_bk0_in   <= {2'b11, line2_r[nxt[3:0]], line1_r[nxt[3:0]]};
                cart_pin31_in <= line31_r[nxt[3:0]];
            end else begin
                // Lines idle high after the last bit
                cart_bk0_in   <= 4'hF;
                cart_pin31_in <= 1'b1;
            end
        end
    end

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_btn(input snac_port_pkg::btn_state_t got,
                             input snac_port_pkg::btn_state_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("error %0t ns: %s buttons %h, expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_busy(input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("error %0t ns: busy %b, expected %b", $time, got, exp));
        end
    endtask

    task automatic check_pin(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("error %0t ns: %s is %b, expected %b",
                                     $time, what, got, exp));
        end
    endtask

    // Model: active-low lines inverted, clocked bits only, SNES_SWAP pairs exchanged
    function automatic snac_port_pkg::btn_state_t expect_word(
        input snac_ctrl_pkg::gc_type_e t,
        input logic [15:0]             line
    );
        snac_port_pkg::btn_state_t w;
        snac_port_pkg::btn_state_t sw;
        int                        nbits;
        nbits = (t == snac_ctrl_pkg::NES) ? `SNAC_NES_BITS : `SNAC_LONG_BITS;
        w = '0;
        for (int k = 0; k < nbits; k++) begin
            w[k] = !line[k];
        end
        sw = w;
        if (t == snac_ctrl_pkg::SNES_SWAP) begin
            for (int k = 0; k < 2; k++) begin
                sw[`SNAC_SWAP_LO + k] = w[`SNAC_SWAP_HI + k];
                sw[`SNAC_SWAP_HI + k] = w[`SNAC_SWAP_LO + k];
            end
        end
        return sw;
    endfunction

    task automatic set_type(input snac_ctrl_pkg::gc_type_e t);
        @(posedge clk);
        game_cont_type <= t;
        // Type register, restart pulse, then poller and mapper clear
        repeat (4) @(posedge clk);
    endtask

    task automatic wait_busy_rise();
        @(negedge clk);
        while (!busy) begin
            @(negedge clk);
        end
    endtask

    // Buttons are valid one cycle after busy falls
    task automatic wait_poll_end();
        wait_busy_rise();
        while (busy) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic run_polls(input snac_ctrl_pkg::gc_type_e t, input int n);
        logic [15:0] data1;
        int          i;
        set_type(t);
        @(negedge clk);
        check_btn(p1_btn, '0, {"player 1 after switch to ", t.name()});
        check_btn(p2_btn, '0, {"player 2 after switch to ", t.name()});
        check_busy(busy, 1'b0);
        for (i = 0; i < n; i++) begin
            wait_poll_end();
            check_busy(busy, 1'b0);
            // DB15 player 1 data is the AND of two lines
            if (t == snac_ctrl_pkg::DB15 || t == snac_ctrl_pkg::DB15_FAST) begin
                data1 = line1_r & line31_r;
            end else begin
                data1 = line1_r;
            end
            check_btn(p1_btn, expect_word(t, data1), $sformatf("%s poll %0d p1", t.name(), i));
            check_btn(p2_btn, expect_word(t, line2_r), $sformatf("%s poll %0d p2", t.name(), i));
        end
    endtask

    task automatic check_disabled(input int cycles);
        int i;
        set_type(snac_ctrl_pkg::DISABLED);
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_pin(cart_bk1_out[7], 1'b0, "latch while disabled");
            check_busy(busy, 1'b0);
            check_btn(p1_btn, '0, "player 1 while disabled");
            check_btn(p2_btn, '0, "player 2 while disabled");
        end
    endtask

    initial begin
        repeat (RESET_CYC) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_btn(p1_btn, '0, "player 1 after reset");
        check_btn(p2_btn, '0, "player 2 after reset");
        check_busy(busy, 1'b0);
        check_pin(cart_bk1_out[7], 1'b0, "latch after reset");
        check_pin(cart_bk1_out[6], 1'b1, "pad clock after reset");
        check_pin(cart_pin30_out, 1'b1, "second pad clock after reset");
        check_pin(cart_bk0_dir, 1'b0, "bank 0 direction");
        check_pin(cart_pin30_dir, 1'b1, "pin 30 direction");
        check_pin(cart_pin31_dir, 1'b0, "pin 31 direction");
        // Input-only pins drive nothing
        for (int b = 4; b <= 7; b++) begin
            check_pin(cart_bk0_out[b], 1'b0, $sformatf("bank 0 output bit %0d", b));
        end
        check_pin(cart_pin31_out, 1'b0, "pin 31 output");
        run_polls(snac_ctrl_pkg::NES, N_NES);
        // Switch in the middle of an NES poll
        wait_busy_rise();
        repeat (STB_COMPAT * 5) @(posedge clk);
        run_polls(snac_ctrl_pkg::SNES, N_LONG);
        run_polls(snac_ctrl_pkg::SNES_SWAP, N_LONG);
        run_polls(snac_ctrl_pkg::DB15, N_LONG);
        run_polls(snac_ctrl_pkg::DB15_FAST, N_LONG);
        wait_busy_rise();
        repeat (STB_FAST * 5) @(posedge clk);
        run_polls(snac_ctrl_pkg::NES, N_CHANGE);
        // Disable while the latch is high
        wait_busy_rise();
        check_disabled(OFF_CYC);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== snac_adapter_top.f ====
+incdir+design
design/snac_ctrl_pkg.sv
design/snac_port_pkg.sv
design/fract_strobe_gen.sv
design/snac_mode_ctrl.sv
design/serlatch_poller.sv
design/button_mapper.sv
design/snac_adapter_top.sv
sim/snac_adapter_assert.sv
sim/tb_snac_adapter.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_snac_adapter \
    -f snac_adapter_top.f -o tb_snac_adapter > build.log 2>&1 \
    && ./obj_dir/tb_snac_adapter > sim.log 2>&1 \
    || echo "build or simulation returned an error"
grep -q "^TB PASSED$" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
